// ==== hdl/pack_data_pkg.sv ====
package pack_data_pkg;

    // ----------------------------------------------------------------------
    // unit and word shape
    // ----------------------------------------------------------------------

    localparam int UNIT_W = 8;                  // bits per unit

    typedef logic [UNIT_W-1:0] unit_t;          // one byte unit

    // default units per beat
    localparam int S_NUM_DEF = 3;               // input beat, e.g. one rgb pixel
    localparam int M_NUM_DEF = 4;               // output word

    // output alignment offset, valid with first
    typedef logic [1:0] align_t;                // covers M_NUM up to 4

endpackage

// ==== hdl/pack_route_pkg.sv ====
package pack_route_pkg;

    // ----------------------------------------------------------------------
    // lane routing
    // ----------------------------------------------------------------------

    localparam int MAX_LANES = 8;               // upper bound for NUM_LANES

    // round-robin lane pointer, shared by dispatch and collect
    typedef logic [2:0] lane_idx_t;

endpackage

// ==== hdl/pack_stream_if.sv ====
`timescale 1ns/1ns

interface pack_stream_if #(
    parameter int NUM = 3                       // units per beat
);

    logic                             first;
    logic                             last;
    pack_data_pkg::unit_t [NUM-1:0]   data;     // unit 0 in the low bits
    pack_data_pkg::align_t            align;    // only meaningful with first
    logic                             valid;
    logic                             ready;

    // producer side
    modport src (output first, last, data, align, valid, input ready);

    // consumer side
    modport snk (input first, last, data, align, valid, output ready);

endinterface

// ==== hdl/packet_dispatch.sv ====
`timescale 1ns/1ns

module packet_dispatch #(
    parameter int NUM_LANES = 4
) (
    input  logic       clk,
    input  logic       reset,
    pack_stream_if.snk in,
    pack_stream_if.src lanes [NUM_LANES]
);

    localparam pack_route_pkg::lane_idx_t LAST_LANE =
        pack_route_pkg::lane_idx_t'(NUM_LANES - 1);

    pack_route_pkg::lane_idx_t ptr;             // lane that owns the current packet

    logic [pack_route_pkg::MAX_LANES-1:0] lane_ready;

    // ----------------------------------------------------------------------
    // steer beats to the pointed lane
    // ----------------------------------------------------------------------

    for (genvar i = 0; i < pack_route_pkg::MAX_LANES; i++) begin : g_lane
        if (i < NUM_LANES) begin : g_used
            assign lanes[i].first = in.first;
            assign lanes[i].last  = in.last;
            assign lanes[i].data  = in.data;
            assign lanes[i].align = in.align;
            assign lanes[i].valid = in.valid && (ptr == pack_route_pkg::lane_idx_t'(i));
            assign lane_ready[i]  = lanes[i].ready;
        end else begin : g_unused
            assign lane_ready[i] = 1'b0;       // never selected
        end
    end

    // only the owning lane can stall the input
    assign in.ready = lane_ready[ptr];

    // ----------------------------------------------------------------------
    // round-robin pointer
    // ----------------------------------------------------------------------

    always_ff @(posedge clk) begin
        if (reset) begin
            ptr <= '0;
        end else if (in.valid && in.ready && in.last) begin
            // whole packet handed over, move on
            ptr <= (ptr == LAST_LANE) ? '0 : ptr + 1'b1;
        end
    end

    // pointer wraps before leaving the built lanes
    a_ptr_range : assert property (
        @(posedge clk) disable iff (reset)
        ptr <= LAST_LANE
    );

endmodule

// ==== hdl/width_pack_lane.sv ====
`timescale 1ns/1ns

module width_pack_lane #(
    parameter int S_NUM = 3,
    parameter int M_NUM = 4
) (
    input  logic                 clk,
    input  logic                 reset,
    input  logic                 endian,    // 1: earliest unit in the high bits
    input  pack_data_pkg::unit_t padding,
    pack_stream_if.snk           s,
    pack_stream_if.src           m
);

    localparam int BUF_NUM = S_NUM + M_NUM - 1;    // worst case fill before a word leaves
    localparam int CNT_W   = $clog2(BUF_NUM + 1);

    localparam logic [CNT_W-1:0] BUF_CNT = CNT_W'(BUF_NUM);
    localparam logic [CNT_W-1:0] S_CNT   = CNT_W'(S_NUM);
    localparam logic [CNT_W-1:0] M_CNT   = CNT_W'(M_NUM);

    // ----------------------------------------------------------------------
    // state
    // ----------------------------------------------------------------------

    // buffer keeps units in arrival order, unit 0 is the oldest
    pack_data_pkg::unit_t [BUF_NUM-1:0] store_q, store_n;
    pack_data_pkg::unit_t [M_NUM-1:0]   word_q,  word_n;

    logic [CNT_W-1:0] count_q, count_n;         // filled units in store
    logic             final_q, final_n;         // last beat taken, draining tail
    logic             first_q, first_n;
    logic             last_q,  last_n;
    logic             valid_q, valid_n;

    logic             rdy;

    always_ff @(posedge clk) begin
        if (reset) begin
            count_q <= '0;
            final_q <= 1'b0;
            first_q <= 1'b0;
            last_q  <= 1'b0;
            valid_q <= 1'b0;
        end else begin
            count_q <= count_n;
            final_q <= final_n;
            first_q <= first_n;
            last_q  <= last_n;
            valid_q <= valid_n;
        end
    end

    always_ff @(posedge clk) begin
        store_q <= store_n;
        word_q  <= word_n;
    end

    // ----------------------------------------------------------------------
    // next state
    // ----------------------------------------------------------------------

    always_comb begin
        logic [CNT_W-1:0] idx;

        count_n = count_q;
        store_n = store_q;
        final_n = final_q;
        first_n = first_q;
        last_n  = last_q;
        valid_n = valid_q;
        word_n  = word_q;
        idx     = '0;

        // word leaving this cycle
        if (m.ready) begin
            valid_n = 1'b0;
            if (valid_q) begin
                first_n = 1'b0;
                if (last_q) begin
                    // packet done, back to idle
                    final_n = 1'b0;
                    count_n = '0;
                end else begin
                    store_n = store_q >> (M_NUM * pack_data_pkg::UNIT_W);
                    count_n = count_q - M_CNT;
                end
            end
        end

        // room for a full beat after the shift
        rdy = !final_n && ((BUF_CNT - count_n) >= S_CNT);

        if (s.valid && rdy) begin
            if (s.first) begin
                first_n = 1'b1;
                count_n = CNT_W'(s.align);     // leading units stay as padding
                store_n = {BUF_NUM{padding}};
            end
            if (s.last) begin
                final_n = 1'b1;
            end

            // input beat follows the same endian as the output word
            for (int k = 0; k < S_NUM; k++) begin
                idx = count_n + CNT_W'(k);
                store_n[idx] = endian ? s.data[S_NUM-1-k] : s.data[k];
            end
            count_n = count_n + S_CNT;
        end

        // unfilled part of the head word reads as padding
        for (int j = 0; j < M_NUM; j++) begin
            if (CNT_W'(j) >= count_n) begin
                store_n[j] = padding;
            end
        end

        // a full word, or the tail of the packet
        if (count_n >= M_CNT || final_n) begin
            last_n  = (count_n <= M_CNT) && final_n;
            valid_n = 1'b1;
            for (int j = 0; j < M_NUM; j++) begin
                word_n[j] = endian ? store_n[M_NUM-1-j] : store_n[j];
            end
        end
    end

    // ----------------------------------------------------------------------
    // stream outputs
    // ----------------------------------------------------------------------

    assign s.ready = rdy;

    assign m.first = first_q;
    assign m.last  = last_q;
    assign m.data  = word_q;
    assign m.align = '0;                        // output side carries no offset
    assign m.valid = valid_q;

    // fill never runs past the buffer
    a_count_range : assert property (
        @(posedge clk) disable iff (reset)
        count_q <= BUF_CNT
    );

    // stalled word is held as is
    a_out_hold : assert property (
        @(posedge clk) disable iff (reset)
        m.valid && !m.ready |=> m.valid && $stable(m.data)
                                && $stable(m.first) && $stable(m.last)
    );

endmodule

// ==== hdl/packet_collect.sv ====
`timescale 1ns/1ns

module packet_collect #(
    parameter int NUM_LANES = 4
) (
    input  logic       clk,
    input  logic       reset,
    pack_stream_if.snk lanes [NUM_LANES],
    pack_stream_if.src out
);

    localparam int DATA_W = $bits(out.data);

    localparam pack_route_pkg::lane_idx_t LAST_LANE =
        pack_route_pkg::lane_idx_t'(NUM_LANES - 1);

    pack_route_pkg::lane_idx_t ptr;             // lane whose packet goes out now

    logic [pack_route_pkg::MAX_LANES-1:0] lane_valid;
    logic [pack_route_pkg::MAX_LANES-1:0] lane_first;
    logic [pack_route_pkg::MAX_LANES-1:0] lane_last;
    logic [DATA_W-1:0]                    lane_data [pack_route_pkg::MAX_LANES];

    // ----------------------------------------------------------------------
    // gather lane outputs
    // ----------------------------------------------------------------------

    for (genvar i = 0; i < pack_route_pkg::MAX_LANES; i++) begin : g_lane
        if (i < NUM_LANES) begin : g_used
            assign lane_valid[i]  = lanes[i].valid;
            assign lane_first[i]  = lanes[i].first;
            assign lane_last[i]   = lanes[i].last;
            assign lane_data[i]   = lanes[i].data;
            assign lanes[i].ready = out.ready && (ptr == pack_route_pkg::lane_idx_t'(i));

            // a waiting lane keeps its word until its turn comes
            a_sel_only : assert property (
                @(posedge clk) disable iff (reset)
                lanes[i].valid && ptr != pack_route_pkg::lane_idx_t'(i)
                    |=> lanes[i].valid && $stable(lanes[i].data)
            );
        end else begin : g_unused
            assign lane_valid[i] = 1'b0;
            assign lane_first[i] = 1'b0;
            assign lane_last[i]  = 1'b0;
            assign lane_data[i]  = '0;
        end
    end

    // ----------------------------------------------------------------------
    // forward the pointed lane
    // ----------------------------------------------------------------------

    assign out.valid = lane_valid[ptr];
    assign out.first = lane_first[ptr];
    assign out.last  = lane_last[ptr];
    assign out.data  = lane_data[ptr];
    assign out.align = '0;

    always_ff @(posedge clk) begin
        if (reset) begin
            ptr <= '0;
        end else if (out.valid && out.ready && out.last) begin
            ptr <= (ptr == LAST_LANE) ? '0 : ptr + 1'b1;    // same order as dispatch
        end
    end

endmodule

// ==== hdl/pixel_pack_top.sv ====
`timescale 1ns/1ns

module pixel_pack_top #(
    parameter int NUM_LANES = 4,
    parameter int S_NUM     = pack_data_pkg::S_NUM_DEF,
    parameter int M_NUM     = pack_data_pkg::M_NUM_DEF
) (
    input  logic                                    clk,
    input  logic                                    reset,

    input  logic                                    endian,
    input  pack_data_pkg::unit_t                    padding,

    input  logic                                    in_first,
    input  logic                                    in_last,
    input  logic [S_NUM*pack_data_pkg::UNIT_W-1:0]  in_data,
    input  pack_data_pkg::align_t                   in_align,
    input  logic                                    in_valid,
    output logic                                    in_ready,

    output logic                                    out_first,
    output logic                                    out_last,
    output logic [M_NUM*pack_data_pkg::UNIT_W-1:0]  out_data,
    output logic                                    out_valid,
    input  logic                                    out_ready
);

    pack_stream_if #(.NUM(S_NUM)) in_s ();
    pack_stream_if #(.NUM(S_NUM)) lane_in  [NUM_LANES] ();
    pack_stream_if #(.NUM(M_NUM)) lane_out [NUM_LANES] ();
    pack_stream_if #(.NUM(M_NUM)) out_s ();

    // plain ports onto streams
    assign in_s.first = in_first;
    assign in_s.last  = in_last;
    assign in_s.data  = in_data;
    assign in_s.align = in_align;
    assign in_s.valid = in_valid;
    assign in_ready   = in_s.ready;

    assign out_first   = out_s.first;
    assign out_last    = out_s.last;
    assign out_data    = out_s.data;
    assign out_valid   = out_s.valid;
    assign out_s.ready = out_ready;

    packet_dispatch #(.NUM_LANES(NUM_LANES)) u_dispatch (
        .clk   (clk),
        .reset (reset),
        .in    (in_s),
        .lanes (lane_in)
    );

    for (genvar g = 0; g < NUM_LANES; g++) begin : g_lane
        width_pack_lane #(.S_NUM(S_NUM), .M_NUM(M_NUM)) u_lane (
            .clk     (clk),
            .reset   (reset),
            .endian  (endian),
            .padding (padding),
            .s       (lane_in[g]),
            .m       (lane_out[g])
        );
    end

    packet_collect #(.NUM_LANES(NUM_LANES)) u_collect (
        .clk   (clk),
        .reset (reset),
        .lanes (lane_out),
        .out   (out_s)
    );

endmodule

// ==== verif/pixel_pack_tasks.svh ====
// ----------------------------------------------------------------------
// check and reference model
// ----------------------------------------------------------------------

task automatic check_value(input logic [31:0] got, input logic [31:0] exp, input string what);
    check_count++;
    if (got !== exp) begin
        error_count++;
        $display("CHECK FAILED at %0t ns: %s, got %h, expected %h", $time, what, got, exp);
    end
endtask

// queue one packet and the words it must give
task automatic add_packet(input int beats, input int align);
    pack_data_pkg::unit_t seq [$];
    pack_data_pkg::unit_t u;
    logic [WORD_W-1:0]    word;
    int                   n_words;
    for (int i = 0; i < align; i++) seq.push_back(padding);   // leading offset
    for (int i = 0; i < beats * S_NUM; i++) begin
        u = pack_data_pkg::unit_t'(take_bits(8));
        unit_pool.push_back(u);
        seq.push_back(u);
    end
    while (seq.size() % M_NUM != 0) seq.push_back(padding);
    n_words = seq.size() / M_NUM;
    for (int w = 0; w < n_words; w++) begin
        for (int k = 0; k < M_NUM; k++) begin
            if (endian) word[(M_NUM-1-k)*UNIT_W +: UNIT_W] = seq[w*M_NUM+k];
            else        word[k*UNIT_W +: UNIT_W] = seq[w*M_NUM+k];
        end
        exp_q.push_back({w == 0, w == n_words - 1, word});
    end
    pkt_beats.push_back(beats);
    pkt_align.push_back(align);
endtask

// ----------------------------------------------------------------------
// stream drivers
// ----------------------------------------------------------------------

task automatic drive_packets();
    int beats;
    int align;
    while (pkt_beats.size() > 0) begin
        beats = pkt_beats.pop_front();
        align = pkt_align.pop_front();
        for (int b = 0; b < beats; b++) begin
            @(negedge clk);
            in_valid = 1'b1;
            in_first = (b == 0);
            in_last  = (b == beats - 1);
            in_align = (b == 0) ? pack_data_pkg::align_t'(align) : pack_data_pkg::align_t'(0);
            for (int k = 0; k < S_NUM; k++) begin
                if (endian) in_data[(S_NUM-1-k)*UNIT_W +: UNIT_W] = unit_pool.pop_front();
                else        in_data[k*UNIT_W +: UNIT_W] = unit_pool.pop_front();
            end
            do begin
                @(posedge clk);
            end while (!in_ready);
        end
    end
    @(negedge clk);
    in_valid = 1'b0;
    in_first = 1'b0;
    in_last  = 1'b0;
endtask

task automatic collect_words(input logic stall);
    logic [WORD_W+1:0] exp_word;
    int                n_got;
    n_got = 0;
    while (exp_q.size() > 0) begin
        @(negedge clk);
        out_ready = stall ? (take_bits(1) != 0) : 1'b1;   // random back-pressure
        @(posedge clk);
        if (out_valid && out_ready) begin
            exp_word = exp_q.pop_front();
            check_value(out_data, exp_word[WORD_W-1:0], $sformatf("data of word %0d", n_got));
            check_value(32'(out_first), 32'(exp_word[WORD_W+1]), "out_first");
            check_value(32'(out_last), 32'(exp_word[WORD_W]), "out_last");
            n_got++;
        end
    end
    @(negedge clk);
    out_ready = 1'b1;
endtask

task automatic run_queued(input logic stall);
    fork
        drive_packets();
        collect_words(stall);
    join
    repeat (3) begin
        @(posedge clk);
        check_value(32'(out_valid), 32'd0, "out_valid after the last word");   // no extra word
    end
endtask

// ----------------------------------------------------------------------
// directed tests
// ----------------------------------------------------------------------

task automatic test_reset_state();
    @(posedge clk);
    check_value(32'(out_valid), 32'd0, "out_valid after reset");
    check_value(32'(in_ready), 32'd1, "in_ready after reset");
endtask

task automatic set_mode(input logic big, input pack_data_pkg::unit_t pad);
    @(negedge clk);
    endian  = big;
    padding = pad;
endtask

task automatic test_single_little();
    set_mode(1'b0, 8'ha5);
    words_seen = 0;
    add_packet(4, 0);
    run_queued(1'b0);
    check_value(32'(words_seen), 32'd3, "word count of a 4-beat packet");
endtask

task automatic test_tail_padding();
    set_mode(1'b0, 8'h5a);
    add_packet(1, 0);                       // 3 units, one pad
    add_packet(2, 0);
    add_packet(3, 0);
    add_packet(5, 0);
    run_queued(1'b0);
endtask

task automatic test_align_offsets();
    set_mode(1'b0, 8'hc3);
    add_packet(2, 1);
    add_packet(3, 2);
    add_packet(1, 3);
    run_queued(1'b0);
endtask

task automatic test_big_endian();
    set_mode(1'b1, 8'h3c);
    add_packet(3, 0);
    add_packet(2, 2);
    run_queued(1'b0);
endtask

task automatic test_random_stream();
    set_mode(take_bits(1) != 0, pack_data_pkg::unit_t'(take_bits(8)));
    for (int p = 0; p < 12; p++) begin
        add_packet(int'(take_bits(3)) + 1, int'(take_bits(2)));
    end
    run_queued(1'b1);
endtask

// ==== verif/pixel_pack_tb.sv ====
`timescale 1ns/1ns

module pixel_pack_tb;

    localparam int UNIT_W      = pack_data_pkg::UNIT_W;
    localparam int S_NUM       = pack_data_pkg::S_NUM_DEF;
    localparam int M_NUM       = pack_data_pkg::M_NUM_DEF;
    localparam int WORD_W      = M_NUM * UNIT_W;
    localparam int FIXED_BEATS = 26;        // directed packets of tests 2 to 5
    localparam int RAND_BEATS  = 12 * 8;    // 12 packets of at most 8 beats
    localparam int CYCLE_LIMIT = 10 * (FIXED_BEATS + RAND_BEATS) + 200;

    logic                    clk;
    logic                    reset;
    logic                    endian;
    pack_data_pkg::unit_t    padding;
    logic                    in_first;
    logic                    in_last;
    logic [S_NUM*UNIT_W-1:0] in_data;
    pack_data_pkg::align_t   in_align;
    logic                    in_valid;
    logic                    in_ready;
    logic                    out_first;
    logic                    out_last;
    logic [WORD_W-1:0]       out_data;
    logic                    out_valid;
    logic                    out_ready;

    logic [31:0]             lfsr_state;
    int                      error_count;
    int                      check_count;
    int                      cycle_count;
    int                      words_seen;

    // reference model, one {first, last, data} entry per expected word
    logic [WORD_W+1:0]       exp_q [$];
    pack_data_pkg::unit_t    unit_pool [$];    // data units not yet sent
    int                      pkt_beats [$];
    int                      pkt_align [$];

    pixel_pack_top #(
        .NUM_LANES (4),
        .S_NUM     (S_NUM),
        .M_NUM     (M_NUM)
    ) dut0 (
        .clk       (clk),
        .reset     (reset),
        .endian    (endian),
        .padding   (padding),
        .in_first  (in_first),
        .in_last   (in_last),
        .in_data   (in_data),
        .in_align  (in_align),
        .in_valid  (in_valid),
        .in_ready  (in_ready),
        .out_first (out_first),
        .out_last  (out_last),
        .out_data  (out_data),
        .out_valid (out_valid),
        .out_ready (out_ready)
    );

    always #10 clk = ~clk;

    // words handed over by the DUT
    always @(posedge clk) begin
        if (!reset && out_valid && out_ready) begin
            words_seen++;
        end
    end

    // fibonacci lfsr, taps 32 22 2 1, one step per bit
    function automatic logic [31:0] take_bits(input int n);
        logic [31:0] bits;
        logic        fb;
        bits = '0;
        for (int i = 0; i < n; i++) begin
            fb         = lfsr_state[31] ^ lfsr_state[21] ^ lfsr_state[1] ^ lfsr_state[0];
            lfsr_state = {lfsr_state[30:0], fb};
            bits       = {bits[30:0], fb};
        end
        return bits;
    endfunction

    `include "pixel_pack_tasks.svh"

    // ----------------------------------------------------------------------
    // run limit
    // ----------------------------------------------------------------------

    initial begin
        cycle_count = 0;
        while (cycle_count < CYCLE_LIMIT) begin
            @(posedge clk);
            cycle_count++;
        end
        $display("timeout: run still busy after %0d clock cycles", CYCLE_LIMIT);
        $display("errors: %0d of %0d checks", error_count, check_count);
        $display("Verification failed");
        $finish;
    end

    // ----------------------------------------------------------------------
    // test sequence
    // ----------------------------------------------------------------------

    initial begin
        clk         = 1'b0;
        reset       = 1'b1;
        endian      = 1'b0;
        padding     = '0;
        in_first    = 1'b0;
        in_last     = 1'b0;
        in_data     = '0;
        in_align    = '0;
        in_valid    = 1'b0;
        out_ready   = 1'b1;
        lfsr_state  = 32'he8b44e3f;
        error_count = 0;
        check_count = 0;
        words_seen  = 0;

        repeat (4) @(posedge clk);
        @(negedge clk);
        reset = 1'b0;

        test_reset_state();
        test_single_little();
        test_tail_padding();
        test_align_offsets();
        test_big_endian();
        test_random_stream();

        $display("errors: %0d of %0d checks", error_count, check_count);
        if (error_count == 0) begin
            $display("Verification passed");
        end else begin
            $display("Verification failed");
        end
        $finish;
    end

endmodule

// ==== pixel_pack.f ====
+incdir+verif
hdl/pack_data_pkg.sv
hdl/pack_route_pkg.sv
hdl/pack_stream_if.sv
hdl/packet_dispatch.sv
hdl/width_pack_lane.sv
hdl/packet_collect.sv
hdl/pixel_pack_top.sv
verif/pixel_pack_tb.sv

// ==== Makefile ====
# Verilator flow for the pixel packer

VERILATOR ?= verilator
FILELIST  ?= pixel_pack.f
RTL_TOP   ?= pixel_pack_top
TB_TOP    ?= pixel_pack_tb
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --timing --assert

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) --lint-only $(VFLAGS) -f $(FILELIST) --top-module $(RTL_TOP)

sim:
	$(VERILATOR) --binary $(VFLAGS) -f $(FILELIST) --top-module $(TB_TOP) \
		-Mdir $(BUILD_DIR) -o $(TB_TOP)
	./$(BUILD_DIR)/$(TB_TOP) 2>&1 | tee $(LOG)
	@if grep -q "Verification failed" $(LOG); then \
		echo "simulation reported failure, see $(LOG)"; exit 1; fi
	@if ! grep -q "Verification passed" $(LOG); then \
		echo "simulation ended without a result, see $(LOG)"; exit 1; fi

clean:
	rm -rf $(BUILD_DIR) $(LOG)
